/* design/rv_alu.sv */
// Arithmetic and logic unit with the branch comparator
// Both halves are combinational and work side by side

module rv_alu (
    input  logic [31:0]          a_i,
    input  logic [31:0]          b_i,
    input  rv_core_pkg::alu_op_e alu_op_i,
    input  logic [31:0]          cmp_a_i,
    input  logic [31:0]          cmp_b_i,
    input  rv_core_pkg::cmp_op_e cmp_op_i,
    output logic [31:0]          result_o,
    output logic                 cmp_result_o
);
    import rv_core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];                 // Upper bits ignored

    ////////////////////
    // ALU
    ////////////////////
    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: result_o = {31'd0, a_i < b_i};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = $signed(a_i) >>> shamt;  // Sign fill
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = 32'd0;
        endcase
    end

    ////////////////////
    // Comparator
    ////////////////////
    always_comb begin
        case (cmp_op_i)
            CMP_ALWAYS: cmp_result_o = 1'b1;             // JAL, JALR
            CMP_EQ:     cmp_result_o = (cmp_a_i == cmp_b_i);
            CMP_NE:     cmp_result_o = (cmp_a_i != cmp_b_i);
            CMP_LT:     cmp_result_o = ($signed(cmp_a_i) < $signed(cmp_b_i));
            CMP_GE:     cmp_result_o = ($signed(cmp_a_i) >= $signed(cmp_b_i));
            CMP_LTU:    cmp_result_o = (cmp_a_i < cmp_b_i);
            CMP_GEU:    cmp_result_o = (cmp_a_i >= cmp_b_i);
            default:    cmp_result_o = 1'b0;             // NEVER
        endcase
    end

endmodule

/* design/rv_core.sv */
// RV32I two-stage core
// Fetch feeds execute, execute redirects fetch on a taken jump

module rv_core (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   hlt_i,
    output logic [31:0]            imem_addr_o,
    input  logic [31:0]            imem_data_i,
    output rv_core_pkg::dmem_req_t dmem_req_o,
    input  logic [31:0]            dmem_rdata_i
);
    import rv_isa_pkg::*;

    instr_u      instr;                      // Fetch-to-execute register
    logic [31:0] pc_old;
    logic [31:0] link_addr;
    logic        jump_taken;                 // Redirect back to fetch
    logic [31:0] jump_target;

    rv_fetch i_fetch (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .hlt_i         (hlt_i),
        .jump_taken_i  (jump_taken),
        .jump_target_i (jump_target),
        .imem_data_i   (imem_data_i),
        .imem_addr_o   (imem_addr_o),
        .instr_o       (instr),
        .pc_old_o      (pc_old),
        .link_addr_o   (link_addr)
    );

    rv_execute i_execute (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .hlt_i         (hlt_i),
        .instr_i       (instr),
        .pc_old_i      (pc_old),
        .link_addr_i   (link_addr),
        .dmem_rdata_i  (dmem_rdata_i),
        .dmem_req_o    (dmem_req_o),
        .jump_taken_o  (jump_taken),
        .jump_target_o (jump_target)
    );

endmodule

/* design/rv_core_pkg.sv */
// RV32I core internal control
// Decoded control word, unit selectors and the data memory request

package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // Comparator, branches and SLT/SLTI write-back
    typedef enum logic [2:0] {
        CMP_ALWAYS, CMP_EQ, CMP_NE, CMP_LT,
        CMP_GE, CMP_LTU, CMP_GEU, CMP_NEVER
    } cmp_op_e;

    typedef enum logic [2:0] {
        WB_IMM,                              // LUI
        WB_LINK,                             // JAL/JALR return address
        WB_ALU,
        WB_CMP,                              // SLT/SLTU result bit
        WB_LOAD
    } wb_sel_e;

    // Same code as funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_width_e;

    typedef struct packed {
        logic [4:0]  rd, rs1, rs2;
        logic [31:0] imm;                    // Sign-extended per format
        logic        jump_en;                // Jump when cmp_op holds
        cmp_op_e     cmp_op;
        logic        rf_we;
        wb_sel_e     wb_sel;
        logic        a_is_pc;                // ALU a from PC, else rs1
        logic        b_is_imm;               // ALU b from imm, else rs2
        logic        cmp_b_is_imm;           // Comparator b, SLTI/SLTIU
        alu_op_e     alu_op;
        mem_width_e  mem_width;
        logic        mem_we;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        mem_width_e  width;
        logic        we;
    } dmem_req_t;

endpackage

/* design/rv_decode.sv */
// Instruction decoder
// Turns the instruction word into the control word and immediate, purely combinational

module rv_decode (
    input  rv_isa_pkg::instr_u  instr_i,
    output rv_core_pkg::ctrl_t  ctrl_o
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0]  funct3;
    logic        alt;                        // funct7 bit 5, SUB and SRA

    // ALU op for OP_IMM and OP_REG
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            F3_ADD:  return sub_sra ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return sub_sra ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    ////////////////////
    // Immediates by format
    ////////////////////
    assign imm_i = {{20{instr_i.i_type.imm[11]}}, instr_i.i_type.imm};
    assign imm_s = {{20{instr_i.s_type.imm_11_5[6]}}, instr_i.s_type.imm_11_5,
                    instr_i.s_type.imm_4_0};
    assign imm_b = {{19{instr_i.b_type.imm_12}}, instr_i.b_type.imm_12,
                    instr_i.b_type.imm_11, instr_i.b_type.imm_10_5,
                    instr_i.b_type.imm_4_1, 1'b0};
    assign imm_u = {instr_i.u_type.imm_31_12, 12'b0};
    assign imm_j = {{11{instr_i.j_type.imm_20}}, instr_i.j_type.imm_20,
                    instr_i.j_type.imm_19_12, instr_i.j_type.imm_11,
                    instr_i.j_type.imm_10_1, 1'b0};

    assign funct3 = instr_i.r_type.funct3;
    assign alt    = instr_i.r_type.funct7[5];

    ////////////////////
    // Control per opcode
    ////////////////////
    always_comb begin
        ctrl_o           = '0;               // NOP unless an opcode matches
        ctrl_o.cmp_op    = CMP_NEVER;
        ctrl_o.wb_sel    = WB_ALU;
        ctrl_o.alu_op    = ALU_ADD;
        ctrl_o.mem_width = mem_width_e'(funct3);
        ctrl_o.rd        = instr_i.r_type.rd;
        ctrl_o.rs1       = instr_i.r_type.rs1;
        ctrl_o.rs2       = instr_i.r_type.rs2;

        case (instr_i.r_type.opcode)
            OP_LUI: begin
                ctrl_o.imm    = imm_u;
                ctrl_o.rf_we  = 1'b1;
                ctrl_o.wb_sel = WB_IMM;
            end
            OP_AUIPC: begin
                ctrl_o.imm      = imm_u;
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.a_is_pc  = 1'b1;      // PC + imm
                ctrl_o.b_is_imm = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                ctrl_o.imm      = (instr_i.r_type.opcode == OP_JAL) ? imm_j : imm_i;
                ctrl_o.a_is_pc  = (instr_i.r_type.opcode == OP_JAL);  // JALR uses rs1
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.jump_en  = 1'b1;
                ctrl_o.cmp_op   = CMP_ALWAYS;
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.wb_sel   = WB_LINK;
            end
            OP_BRANCH: begin
                ctrl_o.imm      = imm_b;
                ctrl_o.a_is_pc  = 1'b1;      // Target PC + imm, rs1 vs rs2 compared
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.jump_en  = 1'b1;
                case (funct3)
                    F3_BEQ:  ctrl_o.cmp_op = CMP_EQ;
                    F3_BNE:  ctrl_o.cmp_op = CMP_NE;
                    F3_BLT:  ctrl_o.cmp_op = CMP_LT;
                    F3_BGE:  ctrl_o.cmp_op = CMP_GE;
                    F3_BLTU: ctrl_o.cmp_op = CMP_LTU;
                    F3_BGEU: ctrl_o.cmp_op = CMP_GEU;
                    default: ctrl_o.cmp_op = CMP_NEVER;
                endcase
            end
            OP_LOAD: begin
                ctrl_o.imm      = imm_i;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.wb_sel   = WB_LOAD;
            end
            OP_STORE: begin
                ctrl_o.imm      = imm_s;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.mem_we   = 1'b1;
            end
            OP_IMM, OP_REG: begin
                ctrl_o.imm          = imm_i;
                ctrl_o.rf_we        = 1'b1;
                ctrl_o.b_is_imm     = (instr_i.r_type.opcode == OP_IMM);
                ctrl_o.cmp_b_is_imm = (instr_i.r_type.opcode == OP_IMM);
                // ADDI has no SUB form, only shifts read bit 30 there
                ctrl_o.alu_op = alu_from_f3(funct3, alt &&
                    (instr_i.r_type.opcode == OP_REG || funct3 == F3_SR));
                if (funct3 == F3_SLT || funct3 == F3_SLTU) begin
                    ctrl_o.wb_sel = WB_CMP;  // Result bit from the comparator
                    ctrl_o.cmp_op = (funct3 == F3_SLT) ? CMP_LT : CMP_LTU;
                end
            end
            default: ctrl_o.rf_we = 1'b0;    // Unknown opcode, behave as NOP
        endcase
    end

endmodule

/* design/rv_execute.sv */
// Decode and execute stage
// One instruction per cycle through decode, register file, ALU and write-back

module rv_execute (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   hlt_i,         // Blocks register and memory writes
    input  rv_isa_pkg::instr_u     instr_i,
    input  logic [31:0]            pc_old_i,
    input  logic [31:0]            link_addr_i,
    input  logic [31:0]            dmem_rdata_i,
    output rv_core_pkg::dmem_req_t dmem_req_o,
    output logic                   jump_taken_o,
    output logic [31:0]            jump_target_o
);
    import rv_core_pkg::*;

    ctrl_t       ctrl;
    logic [31:0] rs1_data, rs2_data;
    logic [31:0] alu_a, alu_b, cmp_b;
    logic [31:0] alu_result;
    logic        cmp_result;
    logic [31:0] load_data;
    logic [31:0] rd_data;

    rv_decode i_decode (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    rv_regfile i_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .we_i       (ctrl.rf_we && !hlt_i),
        .rd_i       (ctrl.rd),
        .rs1_i      (ctrl.rs1),
        .rs2_i      (ctrl.rs2),
        .rd_data_i  (rd_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // Operand muxes
    assign alu_a = ctrl.a_is_pc      ? pc_old_i : rs1_data;
    assign alu_b = ctrl.b_is_imm     ? ctrl.imm : rs2_data;
    assign cmp_b = ctrl.cmp_b_is_imm ? ctrl.imm : rs2_data;

    rv_alu i_alu (
        .a_i          (alu_a),
        .b_i          (alu_b),
        .alu_op_i     (ctrl.alu_op),
        .cmp_a_i      (rs1_data),
        .cmp_b_i      (cmp_b),
        .cmp_op_i     (ctrl.cmp_op),
        .result_o     (alu_result),
        .cmp_result_o (cmp_result)
    );

    ////////////////////
    // Load extension and write-back
    ////////////////////
    always_comb begin
        case (ctrl.mem_width)
            MEM_B:   load_data = {{24{dmem_rdata_i[7]}}, dmem_rdata_i[7:0]};
            MEM_H:   load_data = {{16{dmem_rdata_i[15]}}, dmem_rdata_i[15:0]};
            MEM_W:   load_data = dmem_rdata_i;
            MEM_BU:  load_data = {24'd0, dmem_rdata_i[7:0]};
            MEM_HU:  load_data = {16'd0, dmem_rdata_i[15:0]};
            default: load_data = 32'd0;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_IMM:  rd_data = ctrl.imm;
            WB_LINK: rd_data = link_addr_i;
            WB_ALU:  rd_data = alu_result;
            WB_CMP:  rd_data = {31'd0, cmp_result};
            WB_LOAD: rd_data = load_data;
            default: rd_data = 32'd0;
        endcase
    end

    // Address from rs1 + imm, store data straight from rs2
    assign dmem_req_o = '{addr:  alu_result,
                          wdata: rs2_data,
                          width: ctrl.mem_width,
                          we:    ctrl.mem_we && !hlt_i};

    assign jump_taken_o  = ctrl.jump_en && cmp_result;
    assign jump_target_o = alu_result;       // Fetch clears bit 0

    // Decoded store width must be one the memory understands
    a_store_width: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_req_o.we |-> dmem_req_o.width inside {MEM_B, MEM_H, MEM_W, MEM_BU, MEM_HU});

endmodule

/* design/rv_fetch.sv */
// Fetch stage of the RV32I core
// Program counter with jump redirect, plus the fetch-to-execute register

`include "rv_params.svh"

module rv_fetch (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               hlt_i,        // Freeze PC and stage register
    input  logic               jump_taken_i,
    input  logic [31:0]        jump_target_i,
    input  logic [31:0]        imem_data_i,
    output logic [31:0]        imem_addr_o,
    output rv_isa_pkg::instr_u instr_o,
    output logic [31:0]        pc_old_o,     // PC of the word in instr_o
    output logic [31:0]        link_addr_o   // That PC plus 4
);
    import rv_isa_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] pc_plus4;
    instr_u      instr_q;
    logic [31:0] pc_old_q;
    logic [31:0] link_q;

    assign pc_plus4 = pc_q + 32'd4;

    ////////////////////
    // PC and instruction register
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q        <= `RV_RESET_PC;
            instr_q.raw <= `RV_NOP;
        end else if (!hlt_i) begin
            if (jump_taken_i) begin
                pc_q        <= {jump_target_i[31:1], 1'b0};  // JALR clears bit 0
                instr_q.raw <= `RV_NOP;                      // Kill the word at A+4
            end else begin
                pc_q        <= pc_plus4;
                instr_q.raw <= imem_data_i;
            end
        end
    end

    // Payload alongside the instruction
    always_ff @(posedge clk_i) begin
        if (!hlt_i) begin
            pc_old_q <= pc_q;
            link_q   <= pc_plus4;
        end
    end

    assign imem_addr_o = pc_q;
    assign instr_o     = instr_q;
    assign pc_old_o    = pc_old_q;
    assign link_addr_o = link_q;

    // Redirects from execute never leave the PC halfword-odd
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i) !pc_q[0]);

endmodule

/* design/rv_isa_pkg.sv */
// RV32I instruction encoding
// Major opcodes, funct3 codes and the instruction word with its format views

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,              // Register-immediate ALU
        OP_REG    = 7'b0110011               // Register-register ALU
    } opcode_e;

    // ALU funct3, shared by OP_IMM and OP_REG
    localparam logic [2:0] F3_ADD  = 3'b000;  // ADD/SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL/SRA, split by funct7 bit 5
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } r_type;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } i_type;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            opcode_e    opcode;
        } s_type;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            opcode_e    opcode;
        } b_type;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            opcode_e     opcode;
        } u_type;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            opcode_e    opcode;
        } j_type;
    } instr_u;

endpackage

/* design/rv_params.svh */
// RV32I core parameters
// Reset vector, bubble encoding and register count shared by fetch and regfile

`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

////////////////////
// Fetch
////////////////////

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0, the bubble after reset and on a taken jump
`define RV_NOP      32'h0000_0013

////////////////////
// Register file
////////////////////

`define RV_NUM_REGS 32                   // x0..x31, x0 hardwired to zero

`endif

/* design/rv_regfile.sv */
// Integer register file
// 32 x 32 bits, one synchronous write port and two combinational read ports

`include "rv_params.svh"

module rv_regfile (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        we_i,
    input  logic [4:0]  rd_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic [31:0] rd_data_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o
);

    logic [31:0] regs_q [`RV_NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            regs_q <= '{default: '0};
        end else if (we_i && rd_i != 5'd0) begin  // Writes to x0 dropped
            regs_q[rd_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_i == 5'd0) ? 32'd0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? 32'd0 : regs_q[rs2_i];

    // x0 storage untouched by any write-back
    a_x0_zero: assert property (@(posedge clk_i) disable iff (rst_i) regs_q[0] == 32'd0);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the RV32I core testbench with Verilator

verilator --binary --timing --assert -f tb.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_core > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* sim/tb_clock.sv */
// Testbench clock and reset source
// 100 ns clock, synchronous reset held for the first 16 cycles

module tb_clock (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        repeat (16) @(negedge clk_o);        // 16 rising edges in reset
        rst_o <= 1'b0;                       // Released on a falling edge
    end

    always #50 clk_o = ~clk_o;

endmodule

/* sim/tb_rv_core.sv */
// Testbench for the RV32I two-stage core
// Random program in instruction memory, checked against a sequential ISA model

`include "rv_params.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    localparam int DUMP_IDX   = 220;         // First of the 31 register dump stores
    localparam int LOOP_IDX   = 251;         // Final self-loop
    localparam int MAX_CYCLES = 20000;

    logic        clk, rst, hlt;
    logic [31:0] imem_addr, imem_data, dmem_rdata;
    dmem_req_t   dmem_req;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];                  // DUT side data memory
    logic [31:0] m_mem [64];                 // Model copy
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;

    tb_clock i_clock (.clk_o(clk), .rst_o(rst));

    rv_core i_dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .hlt_i        (hlt),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata)
    );

    // Byte lane merge, little endian
    function automatic logic [31:0] lane_merge(input logic [31:0] old, data,
                                               input logic [1:0] ofs, input logic [2:0] width);
        logic [31:0] mask;
        mask = (width[1:0] == 2'd0) ? 32'h0000_00ff :
               (width[1:0] == 2'd1) ? 32'h0000_ffff : 32'hffff_ffff;
        mask = mask << {ofs, 3'b000};
        return (old & ~mask) | ((data << {ofs, 3'b000}) & mask);
    endfunction

    ////////////////////
    // Memories
    ////////////////////
    always_comb imem_data = imem[imem_addr[9:2]];
    always_comb dmem_rdata = dmem[dmem_req.addr[7:2]] >> {dmem_req.addr[1:0], 3'b000};

    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[7:2]] <= lane_merge(dmem[dmem_req.addr[7:2]], dmem_req.wdata,
                                                   dmem_req.addr[1:0], dmem_req.width);
        end
    end

    ////////////////////
    // Instruction encoders
    ////////////////////
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_word(input opcode_e op, input logic [4:0] rd,
                                           input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] ofs, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3);
        return {ofs[12], ofs[10:5], rs2, rs1, f3, ofs[4:1], ofs[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] ofs);
        return {ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd, OP_JAL};
    endfunction

    ////////////////////
    // Random program
    ////////////////////
    task automatic build_program();
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        int          k;
        imem[0] = i_word(OP_IMM, 5'd1, 3'b000, 5'd0, 12'h200);  // x1 = data window
        for (int i = 1; i < DUMP_IDX; i++) begin
            rd  = 5'd2 + 5'($urandom % 30);  // x1 never overwritten
            rs1 = 5'($urandom);
            rs2 = 5'($urandom);
            f3  = 3'($urandom);
            k   = 1 + ($urandom % ((DUMP_IDX - i) < 8 ? (DUMP_IDX - i) : 8));  // Forward only
            case ($urandom % 12)
                0, 1, 2, 3: begin
                    imm = 12'($urandom);
                    if (f3 == F3_SLL) imm = {7'd0, imm[4:0]};
                    else if (f3 == F3_SR) imm = {1'b0, imm[10], 5'd0, imm[4:0]};  // SRLI/SRAI
                    imem[i] = i_word(OP_IMM, rd, f3, rs1, imm);
                end
                4, 5, 6: imem[i] = r_word(((f3 == F3_ADD || f3 == F3_SR) && $urandom % 2 == 1) ?
                                          7'h20 : 7'h00, rs2, rs1, f3, rd);
                7: imem[i] = {20'($urandom), rd, ($urandom % 2 == 1) ? OP_LUI : OP_AUIPC};
                8: begin
                    f3 = 3'($urandom % 6);   // B, H, W, W, BU, HU
                    if (f3 == 3'd3) f3 = 3'd2;
                    imm = {4'd0, 8'($urandom)};
                    if (f3[1]) imm[1:0] = 2'b00;
                    else if (f3[0]) imm[0] = 1'b0;
                    imem[i] = i_word(OP_LOAD, rd, f3, 5'd1, imm);
                end
                9: begin
                    f3  = 3'($urandom % 3);
                    imm = {4'd0, 8'($urandom)};
                    if (f3[1]) imm[1:0] = 2'b00;
                    else if (f3[0]) imm[0] = 1'b0;
                    imem[i] = s_word(imm, rs2, 5'd1, f3);
                end
                10: begin
                    f3 = 3'($urandom % 6);
                    if (f3 > 3'd1) f3 = f3 + 3'd2;  // Skip the two reserved codes
                    imem[i] = b_word(13'(k * 4), rs2, rs1, f3);
                end
                default: begin
                    if ($urandom % 2 == 1) imem[i] = j_word(rd, 21'(k * 4));
                    else imem[i] = i_word(OP_JALR, rd, 3'b000, 5'd0,
                                          12'((i + k) * 4) | 12'($urandom % 2));  // Odd target too
                end
            endcase
        end
        for (int r = 1; r < 32; r++) begin
            imem[DUMP_IDX - 1 + r] = s_word(12'(r * 4), 5'(r), 5'd1, 3'b010);
        end
        for (int i = LOOP_IDX; i < 256; i++) imem[i] = j_word(5'd0, 21'd0);  // Self-loop
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic [31:0] a, b,
                                              input logic alt);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(output logic store, output dmem_req_t exp);
        logic [31:0] ins, a, b, imm, res, addr, next_pc, ld;
        logic [2:0]  f3;
        logic        wr, taken;
        ins     = imem[m_pc[9:2]];
        a       = m_regs[ins[19:15]];
        b       = m_regs[ins[24:20]];
        f3      = ins[14:12];
        imm     = {{20{ins[31]}}, ins[31:20]};
        next_pc = m_pc + 32'd4;
        res     = 32'd0;
        wr      = 1'b1;
        taken   = 1'b0;
        store   = 1'b0;
        exp     = '0;
        case (ins[6:0])
            OP_LUI:   res = {ins[31:12], 12'd0};
            OP_AUIPC: res = m_pc + {ins[31:12], 12'd0};
            OP_JAL: begin
                res     = next_pc;
                next_pc = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OP_JALR: begin
                res     = next_pc;
                next_pc = (a + imm) & ~32'd1;
            end
            OP_BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) next_pc = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                             ins[11:8], 1'b0};
            end
            OP_LOAD: begin
                addr = a + imm;
                ld   = m_mem[addr[7:2]] >> {addr[1:0], 3'b000};
                case (f3)
                    3'd0:    res = {{24{ld[7]}}, ld[7:0]};
                    3'd1:    res = {{16{ld[15]}}, ld[15:0]};
                    3'd4:    res = {24'd0, ld[7:0]};
                    3'd5:    res = {16'd0, ld[15:0]};
                    default: res = ld;
                endcase
            end
            OP_STORE: begin
                wr    = 1'b0;
                addr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                store = 1'b1;
                exp   = '{addr: addr, wdata: b, width: mem_width_e'(f3), we: 1'b1};
                m_mem[addr[7:2]] = lane_merge(m_mem[addr[7:2]], b, addr[1:0], f3);
            end
            OP_IMM:  res = alu_model(f3, a, imm, f3 == 3'd5 && ins[30]);  // No SUBI
            OP_REG:  res = alu_model(f3, a, b, ins[30]);
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = res;
        m_pc = next_pc;
    endtask

    ////////////////////
    // Checks
    ////////////////////
    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp, act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_req(input string name, input dmem_req_t exp, act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        logic        store, done, last_hlt;
        dmem_req_t   exp;
        logic [31:0] last_addr, step_pc;
        logic [4:0]  chk_rd;
        int          cycles;
        hlt = 1'b0;
        void'($urandom(32'he323_84dc));
        build_program();
        for (int i = 0; i < 64; i++) begin
            dmem[i]  = 32'(i) * 32'h9e37_79b9 + 32'h0101_0101;
            m_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) m_regs[i] = 32'd0;
        m_pc = `RV_RESET_PC;

        cycles = 0;
        do begin                             // Wait for reset release
            @(negedge clk);
            #1;
            cycles++;
            if (cycles > 40) begin
                $display("Reset was never released");
                abort_run();
            end
        end while (rst);

        check_addr("reset pc", `RV_RESET_PC, imem_addr);
        last_addr = imem_addr;
        last_hlt  = 1'b0;
        done      = 1'b0;
        chk_rd    = 5'd0;
        cycles    = 0;
        while (!done) begin
            store = 1'b0;
            // Destination of the last stepped instruction, committed by now
            check_word($sformatf("register x%0d", chk_rd), m_regs[chk_rd],
                       i_dut.i_execute.i_regfile.regs_q[chk_rd]);
            if (last_hlt) check_addr("halt holds pc", last_addr, imem_addr);
            if (!hlt && i_dut.instr.raw != `RV_NOP) begin
                check_addr("executed pc", m_pc, i_dut.pc_old);  // Redirect target or PC+4
                if (m_pc == 32'(LOOP_IDX * 4)) begin
                    done = 1'b1;
                end else begin
                    step_pc = m_pc;
                    model_step(store, exp);
                    chk_rd = imem[step_pc[9:2]][11:7];  // Unchanged on both sides if no write
                    if (store) check_req("store request", exp, dmem_req);
                end
            end
            if (!store) begin
                exp    = dmem_req;           // Only the strobe matters here
                exp.we = 1'b0;
                check_req("no store", exp, dmem_req);
            end
            last_addr = imem_addr;
            last_hlt  = hlt;
            @(negedge clk);
            hlt = ($urandom % 10 == 0);      // About one cycle in ten
            #1;
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("Timed out before the program reached its final loop");
                abort_run();
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* tb.f */
+incdir+design
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_execute.sv
design/rv_core.sv
sim/tb_clock.sv
sim/tb_rv_core.sv
